//--- files.f
+incdir+hdl
hdl/wl_pkg.sv
hdl/wl_cfg_if.sv
hdl/layer_cfg_regs.sv
hdl/conv_load_weights_controller.sv
hdl/weight_buffer.sv
hdl/weight_tile_sequencer.sv
hdl/weight_load_top.sv
dv/weight_load_properties.sv
dv/weight_load_tb.sv

//--- run.sh
#!/bin/sh
# build and run the weight load testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module weight_load_tb -f files.f -o wl_sim
# keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/wl_sim +verilator+error+limit+1000 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Everything OK"

//--- dv/weight_load_tb.sv
`timescale 1ns/1ps

`include "wl_consts.svh"

module weight_load_tb;
  import wl_pkg::*;

  typedef struct packed {
    logic                 skip_wr;
    logic                 lock_wr;
    layer_mode_e          mode;
    logic [`WL_ADR_W-1:0] nkk;
    logic [`WL_ADR_W-1:0] of;
    logic [`WL_ADR_W-1:0] base;
  } layer_row_t;

  localparam int WAIT_LIMIT = 5000;
  localparam int N_ROWS = 6;

  logic                  clk;
  logic                  reset;
  logic                  cfg_wr;
  cfg_reg_e              cfg_addr;
  logic [`WL_ADR_W-1:0]  cfg_wdata;
  logic                  start;
  logic                  ddr_en;
  logic                  ddr_rd_en;
  logic [`WL_ADR_W-1:0]  ddr_rd_adr;
  logic                  ddr_rd_valid;
  logic [`WL_DATA_W-1:0] ddr_rd_data;
  logic                  wbuf_rd_en;
  logic [`WL_ADR_W-1:0]  wbuf_rd_adr;
  logic [`WL_DATA_W-1:0] wbuf_rd_data;
  logic                  tile_ready;
  logic                  tile_consumed;
  logic                  layer_done;
  logic                  busy;

  layer_row_t layer_tab [N_ROWS];
  int errors;
  logic timed_out;

  // ddr model state set per layer by the main flow
  int cur_base;
  int cur_nkk;
  int req_k;
  int req_j;
  int req_total;
  int cyc;
  int en_left;
  logic [`WL_ADR_W-1:0] ret_adr_q [$];
  int ret_due_q [$];

  weight_load_top DUT (.*);

  always #20 clk = ~clk;

  // fixed mix of the address bits
  function automatic logic [`WL_DATA_W-1:0] data_of(logic [`WL_ADR_W-1:0] adr);
    return {adr[7:0], adr ^ 16'hc35a, adr[15:8]};
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_adr(string name, logic [`WL_ADR_W-1:0] got,
                           logic [`WL_ADR_W-1:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(string name, logic [`WL_DATA_W-1:0] got,
                            logic [`WL_DATA_W-1:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("closing: %0d check errors, %0d assertion failures",
             errors, DUT.u_props.fail_cnt);
    if (errors == 0 && DUT.u_props.fail_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  endtask

  ////////////////////
  // ddr model
  ////////////////////

  always @(negedge clk)
  begin
    cyc++;
    ddr_rd_valid = 1'b0;
    if (ret_due_q.size() > 0 && ret_due_q[0] <= cyc)
    begin
      ddr_rd_valid = 1'b1;
      ddr_rd_data  = data_of(ret_adr_q.pop_front());
      void'(ret_due_q.pop_front());
    end
    // accept level held for a random stretch
    if (en_left == 0)
    begin
      ddr_en  = ($urandom % 3) != 0;
      en_left = 1 + int'($urandom % 6);
    end
    en_left--;
    // sample the request that the next rising edge accepts
    #10;
    if (ddr_rd_en)
    begin
      if (tile_ready)
      begin
        errors++;
        $display("a ddr request was made while tile_ready was high at t=%0t", $time);
      end
      check_adr("ddr_rd_adr", ddr_rd_adr, 16'(cur_base + req_k * cur_nkk + req_j));
      ret_adr_q.push_back(ddr_rd_adr);
      ret_due_q.push_back(cyc + 1 + int'($urandom % 4));
      req_total++;
      req_j++;
      if (req_j == cur_nkk)
      begin
        req_j = 0;
        req_k++;
      end
    end
  end

  ////////////////////
  // host and compute side
  ////////////////////

  task automatic write_reg(cfg_reg_e adr, logic [`WL_ADR_W-1:0] data);
    @(negedge clk);
    cfg_wr    = 1'b1;
    cfg_addr  = adr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_wr = 1'b0;
  endtask

  task automatic wait_tile_ready();
    int n;
    n = 0;
    while (!tile_ready && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!tile_ready)
    begin
      errors++;
      timed_out = 1'b1;
      $display("tile_ready did not rise within %0d cycles", WAIT_LIMIT);
    end
  endtask

  // data of address a-1 shows up while a is driven
  task automatic read_tile(int first, int nkk);
    for (int a = 0; a <= nkk; a++)
    begin
      @(negedge clk);
      if (a > 0)
        check_word("wbuf_rd_data", wbuf_rd_data, data_of(16'(first + a - 1)));
      wbuf_rd_en  = (a < nkk);
      wbuf_rd_adr = 16'(a);
    end
  endtask

  task automatic run_layer(layer_row_t r);
    int rows_per;
    int n_tiles;
    rows_per = (r.mode == MODE_128) ? `WL_ROWS_MODE1 : `WL_ROWS_MODE0;
    n_tiles  = (int'(r.of) + rows_per - 1) / rows_per;
    if (!r.skip_wr)
    begin
      write_reg(REG_MODE, 16'(r.mode));
      write_reg(REG_NKK, r.nkk);
      write_reg(REG_OF, r.of);
      write_reg(REG_BASE, r.base);
    end
    cur_base  = int'(r.base);
    cur_nkk   = int'(r.nkk);
    req_k     = 0;
    req_j     = 0;
    req_total = 0;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_flag("busy", busy, 1'b1);
    for (int t = 0; t < n_tiles; t++)
    begin
      wait_tile_ready();
      if (timed_out)
        return;
      check_adr("request count", 16'(req_total), 16'((t + 1) * cur_nkk));
      read_tile(cur_base + t * cur_nkk, cur_nkk);
      if (r.lock_wr && t == 0)
      begin
        // both writes land while busy and must be dropped
        write_reg(REG_NKK, 16'd7);
        write_reg(REG_BASE, 16'h7777);
      end
      repeat ($urandom % 5) @(negedge clk);
      @(negedge clk);
      tile_consumed = 1'b1;
      @(negedge clk);
      tile_consumed = 1'b0;
      check_flag("tile_ready", tile_ready, 1'b0);
      check_flag("layer_done", layer_done, t == n_tiles - 1);
    end
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("layer_done", layer_done, 1'b0);
  endtask

  initial
  begin
    clk           = 1'b0;
    reset         = 1'b1;
    cfg_wr        = 1'b0;
    cfg_addr      = REG_MODE;
    cfg_wdata     = '0;
    start         = 1'b0;
    ddr_en        = 1'b0;
    ddr_rd_valid  = 1'b0;
    ddr_rd_data   = '0;
    wbuf_rd_en    = 1'b0;
    wbuf_rd_adr   = '0;
    tile_consumed = 1'b0;
    errors        = 0;
    timed_out     = 1'b0;
    cyc           = 0;
    en_left       = 0;
    cur_base      = 0;
    cur_nkk       = 1;
    void'($urandom(66963));

    // skip_wr, lock_wr, mode, nkk, of, base
    layer_tab[0] = '{1'b1, 1'b0, MODE_64, 16'(`WL_RST_NKK), 16'(`WL_RST_OF),
                     16'(`WL_RST_BASE)};
    layer_tab[1] = '{1'b0, 1'b0, MODE_64, 16'd40, 16'd150, 16'h0100};
    layer_tab[2] = '{1'b0, 1'b0, MODE_128, 16'd12, 16'd300, 16'h2000};
    layer_tab[3] = '{1'b0, 1'b0, MODE_128, 16'd1, 16'd128, 16'h0500};
    layer_tab[4] = '{1'b0, 1'b1, MODE_128, 16'd24, 16'd200, 16'h0040};
    // reuses the settings left by row 4
    layer_tab[5] = '{1'b1, 1'b0, MODE_128, 16'd24, 16'd200, 16'h0040};

    repeat (3) @(negedge clk);
    reset = 1'b0;
    check_flag("ddr_rd_en", ddr_rd_en, 1'b0);
    check_flag("tile_ready", tile_ready, 1'b0);
    check_flag("layer_done", layer_done, 1'b0);
    check_flag("busy", busy, 1'b0);

    for (int i = 0; i < N_ROWS; i++)
    begin
      run_layer(layer_tab[i]);
      if (timed_out)
        break;
    end
    finish_run();
  end

endmodule

//--- dv/weight_load_properties.sv
`timescale 1ns/1ps

module weight_load_properties (
  input logic clk,
  input logic reset,
  input logic ddr_en,
  input logic ddr_rd_en,
  input logic tile_ready,
  input logic layer_done,
  input logic busy
);

  // count of failed assertions, read at the end of the run
  int fail_cnt = 0;

  ////////////////////
  // ddr request side
  ////////////////////

  a_rd_needs_en: assert property (@(posedge clk) disable iff (reset) ddr_rd_en |-> ddr_en)
    else
    begin
      fail_cnt++;
      $error("ddr_rd_en high while ddr_en low");
    end

  a_no_rd_ready: assert property (@(posedge clk) disable iff (reset) tile_ready |-> !ddr_rd_en)
    else
    begin
      fail_cnt++;
      $error("ddr request while tile_ready high");
    end

  ////////////////////
  // tile and layer flags
  ////////////////////

  a_done_pulse: assert property (@(posedge clk) disable iff (reset) layer_done |=> !layer_done)
    else
    begin
      fail_cnt++;
      $error("layer_done longer than one cycle");
    end

  a_ready_busy: assert property (@(posedge clk) disable iff (reset) $rose(tile_ready) |-> busy)
    else
    begin
      fail_cnt++;
      $error("tile_ready rose while busy low");
    end

endmodule

bind weight_load_top weight_load_properties u_props (
  .clk        (clk),
  .reset      (reset),
  .ddr_en     (ddr_en),
  .ddr_rd_en  (ddr_rd_en),
  .tile_ready (tile_ready),
  .layer_done (layer_done),
  .busy       (busy)
);

//--- hdl/weight_load_top.sv
`timescale 1ns/1ps

`include "wl_consts.svh"

module weight_load_top (
  input  logic                  clk,
  input  logic                  reset,
  // host register port
  input  logic                  cfg_wr,
  input  wl_pkg::cfg_reg_e      cfg_addr,
  input  logic [`WL_ADR_W-1:0]  cfg_wdata,
  input  logic                  start,
  // ddr request and return
  input  logic                  ddr_en,
  output logic                  ddr_rd_en,
  output logic [`WL_ADR_W-1:0]  ddr_rd_adr,
  input  logic                  ddr_rd_valid,
  input  logic [`WL_DATA_W-1:0] ddr_rd_data,
  // compute side
  input  logic                  wbuf_rd_en,
  input  logic [`WL_ADR_W-1:0]  wbuf_rd_adr,
  output logic [`WL_DATA_W-1:0] wbuf_rd_data,
  output logic                  tile_ready,
  input  logic                  tile_consumed,
  output logic                  layer_done,
  output logic                  busy
);

  wl_cfg_if cfg_if ();

  logic                 load;
  logic                 fill_done;
  logic                 last_tile;
  logic                 buf_wr_en;
  logic [`WL_ADR_W-1:0] buf_wr_adr;

  layer_cfg_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .busy      (busy),
    .cfg       (cfg_if.regs)
  );

  conv_load_weights_controller u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .cfg          (cfg_if.ctrl),
    .ddr_en       (ddr_en),
    .ddr_rd_en    (ddr_rd_en),
    .ddr_rd_adr   (ddr_rd_adr),
    .ddr_rd_valid (ddr_rd_valid),
    .buf_wr_en    (buf_wr_en),
    .buf_wr_adr   (buf_wr_adr),
    .fill_done    (fill_done),
    .last_tile    (last_tile)
  );

  // ddr words go straight into the buffer
  weight_buffer u_wbuf (
    .clk     (clk),
    .wr_en   (buf_wr_en),
    .wr_adr  (buf_wr_adr),
    .wr_data (ddr_rd_data),
    .rd_en   (wbuf_rd_en),
    .rd_adr  (wbuf_rd_adr),
    .rd_data (wbuf_rd_data)
  );

  weight_tile_sequencer u_seq (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .tile_consumed (tile_consumed),
    .fill_done     (fill_done),
    .last_tile     (last_tile),
    .load          (load),
    .tile_ready    (tile_ready),
    .layer_done    (layer_done),
    .busy          (busy)
  );

endmodule

//--- hdl/weight_tile_sequencer.sv
`timescale 1ns/1ps

module weight_tile_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic tile_consumed,
  input  logic fill_done,
  input  logic last_tile,
  output logic load,
  output logic tile_ready,
  output logic layer_done,
  output logic busy
);
  import wl_pkg::*;

  seq_state_e state;
  // last-tile flag from the fill of the tile on offer
  logic last_q;

  ////////////////////
  // layer fsm
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= SEQ_IDLE;
      load       <= 1'b0;
      layer_done <= 1'b0;
      last_q     <= 1'b0;
    end
    else
    begin
      load       <= 1'b0;
      layer_done <= 1'b0;
      case (state)
        SEQ_IDLE:
        begin
          // busy also covers the layer_done cycle
          if (start && !busy)
          begin
            state <= SEQ_LOAD;
            load  <= 1'b1;
          end
        end
        SEQ_LOAD:
        begin
          if (fill_done)
          begin
            state  <= SEQ_READY;
            last_q <= last_tile;
          end
        end
        SEQ_READY:
        begin
          if (tile_consumed)
          begin
            if (last_q)
            begin
              state      <= SEQ_IDLE;
              layer_done <= 1'b1;
            end
            else
            begin
              state <= SEQ_LOAD;
              load  <= 1'b1;
            end
          end
        end
        default:
        begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  assign tile_ready = (state == SEQ_READY);
  assign busy       = (state != SEQ_IDLE) || layer_done;

endmodule

//--- hdl/weight_buffer.sv
`timescale 1ns/1ps

`include "wl_consts.svh"

module weight_buffer (
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [`WL_ADR_W-1:0]  wr_adr,
  input  logic [`WL_DATA_W-1:0] wr_data,
  input  logic                  rd_en,
  input  logic [`WL_ADR_W-1:0]  rd_adr,
  output logic [`WL_DATA_W-1:0] rd_data
);

  logic [`WL_DATA_W-1:0] mem [`WL_BUF_DEPTH];

  // only the low address bits select a word
  logic [`WL_BUF_AW-1:0] wr_idx;
  logic [`WL_BUF_AW-1:0] rd_idx;

  assign wr_idx = wr_adr[`WL_BUF_AW-1:0];
  assign rd_idx = rd_adr[`WL_BUF_AW-1:0];

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_idx] <= wr_data;
  end

  ////////////////////
  // read port
  ////////////////////

  // data one cycle after rd_en, held otherwise
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_data <= mem[rd_idx];
  end

endmodule

//--- hdl/conv_load_weights_controller.sv
`timescale 1ns/1ps

`include "wl_consts.svh"

module conv_load_weights_controller (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load,
  wl_cfg_if.ctrl               cfg,
  input  logic                 ddr_en,
  output logic                 ddr_rd_en,
  output logic [`WL_ADR_W-1:0] ddr_rd_adr,
  input  logic                 ddr_rd_valid,
  output logic                 buf_wr_en,
  output logic [`WL_ADR_W-1:0] buf_wr_adr,
  output logic                 fill_done,
  output logic                 last_tile
);
  import wl_pkg::*;

  // request side
  logic                 req_active;
  logic [`WL_ADR_W-1:0] req_cnt;
  logic                 req_step;
  logic                 req_end;

  // tile position, start channel is 1 based
  logic [`WL_ADR_W-1:0] tof_start;
  logic [`WL_ADR_W-1:0] tof_base;
  logic [`WL_ADR_W-1:0] rows;
  logic [`WL_ADR_W:0]   tof_next_start;
  logic                 tile_is_last;
  logic                 last_flag;

  // buffer write side
  logic [`WL_ADR_W-1:0] wr_cnt;
  logic                 wr_end;

  assign rows = (cfg.mode == MODE_128) ? `WL_ADR_W'(`WL_ROWS_MODE1)
                                       : `WL_ADR_W'(`WL_ROWS_MODE0);

  ////////////////////
  // ddr requests
  ////////////////////

  // a request goes out only when the mig side accepts
  assign req_step = req_active && ddr_en;
  assign req_end  = req_step && (req_cnt == cfg.nkk - 1'b1);

  always_ff @(posedge clk)
  begin
    if (reset)
      req_active <= 1'b0;
    else if (load)
      req_active <= 1'b1;
    else if (req_end)
      req_active <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      req_cnt <= '0;
    else if (req_end)
      req_cnt <= '0;
    else if (req_step)
      req_cnt <= req_cnt + 1'b1;
  end

  assign ddr_rd_en  = req_step;
  assign ddr_rd_adr = cfg.base_adr + tof_base + req_cnt;

  ////////////////////
  // tile advance
  ////////////////////

  // extra bit so a large of cannot wrap the compare
  assign tof_next_start = {1'b0, tof_start} + {1'b0, rows};
  assign tile_is_last   = tof_next_start > {1'b0, cfg.of};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tof_start <= `WL_ADR_W'(1);
      tof_base  <= '0;
      last_flag <= 1'b0;
    end
    else if (req_end)
    begin
      if (tile_is_last)
      begin
        // back to the first tile for the next layer
        tof_start <= `WL_ADR_W'(1);
        tof_base  <= '0;
        last_flag <= 1'b1;
      end
      else
      begin
        tof_start <= tof_next_start[`WL_ADR_W-1:0];
        tof_base  <= tof_base + cfg.nkk;
        last_flag <= 1'b0;
      end
    end
  end

  ////////////////////
  // buffer writes
  ////////////////////

  // returned words arrive in request order
  assign wr_end = ddr_rd_valid && (wr_cnt == cfg.nkk - 1'b1);

  always_ff @(posedge clk)
  begin
    if (reset)
      wr_cnt <= '0;
    else if (wr_end)
      wr_cnt <= '0;
    else if (ddr_rd_valid)
      wr_cnt <= wr_cnt + 1'b1;
  end

  assign buf_wr_en  = ddr_rd_valid;
  assign buf_wr_adr = wr_cnt;
  assign fill_done  = wr_end;
  assign last_tile  = wr_end && last_flag;

endmodule

//--- hdl/layer_cfg_regs.sv
`timescale 1ns/1ps

`include "wl_consts.svh"

module layer_cfg_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cfg_wr,
  input  wl_pkg::cfg_reg_e     cfg_addr,
  input  logic [`WL_ADR_W-1:0] cfg_wdata,
  input  logic                 busy,
  wl_cfg_if.regs               cfg
);
  import wl_pkg::*;

  logic wr_take;

  // settings stay frozen for the whole layer
  assign wr_take = cfg_wr && !busy;

  ////////////////////
  // setting registers
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cfg.mode     <= MODE_64;
      cfg.nkk      <= `WL_ADR_W'(`WL_RST_NKK);
      cfg.of       <= `WL_ADR_W'(`WL_RST_OF);
      cfg.base_adr <= `WL_ADR_W'(`WL_RST_BASE);
    end
    else if (wr_take)
    begin
      case (cfg_addr)
        REG_MODE:
        begin
          // only bit 0 carries the mode
          cfg.mode <= layer_mode_e'(cfg_wdata[0]);
        end
        REG_NKK:
        begin
          cfg.nkk <= cfg_wdata;
        end
        REG_OF:
        begin
          cfg.of <= cfg_wdata;
        end
        REG_BASE:
        begin
          cfg.base_adr <= cfg_wdata;
        end
      endcase
    end
  end

endmodule

//--- hdl/wl_cfg_if.sv
`timescale 1ns/1ps

`include "wl_consts.svh"

interface wl_cfg_if;
  import wl_pkg::*;

  // held layer settings
  layer_mode_e mode;
  // words per output channel tile
  logic [`WL_ADR_W-1:0] nkk;
  // output channel count
  logic [`WL_ADR_W-1:0] of;
  // first ddr word of the layer
  logic [`WL_ADR_W-1:0] base_adr;

  // register block side
  modport regs (
    output mode,
    output nkk,
    output of,
    output base_adr
  );

  // load controller side
  modport ctrl (
    input mode,
    input nkk,
    input of,
    input base_adr
  );

endinterface

//--- hdl/wl_pkg.sv
package wl_pkg;

  ////////////////////
  // layer mode
  ////////////////////

  // picks the number of output channels per tile
  typedef enum logic [0:0] {
    MODE_64  = 1'b0,
    MODE_128 = 1'b1
  } layer_mode_e;

  ////////////////////
  // register map
  ////////////////////

  // host write address, one per layer setting
  typedef enum logic [1:0] {
    REG_MODE = 2'd0,
    REG_NKK  = 2'd1,
    REG_OF   = 2'd2,
    REG_BASE = 2'd3
  } cfg_reg_e;

  ////////////////////
  // tile sequencer
  ////////////////////

  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_LOAD  = 2'd1,
    SEQ_READY = 2'd2
  } seq_state_e;

endpackage

//--- hdl/wl_consts.svh
`ifndef WL_CONSTS_SVH
`define WL_CONSTS_SVH

// word and address widths
`define WL_DATA_W 32
`define WL_ADR_W 16

// weight buffer, depth is also the largest words-per-tile value
`define WL_BUF_DEPTH 1024
`define WL_BUF_AW 10

// output channels per tile for each mode
`define WL_ROWS_MODE0 64
`define WL_ROWS_MODE1 128

// layer settings after reset
`define WL_RST_NKK 16
`define WL_RST_OF 64
`define WL_RST_BASE 0

`endif
